/* Makefile */
# Verilator lint, simulation and clean for the multicycle MIPS core

VERILATOR ?= verilator
TOP       ?= mips_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Everything OK
VFLAGS    ?= --timing --assert
SIM_ARGS  ?= +verilator+error+limit+10

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o V$(TOP)

# Pass only when the log holds the pass message
sim: build
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* all.f */
verilog/mips_pkg.sv
verilog/mips_ctrl_if.sv
verilog/mips_control.sv
verilog/mips_fetch_unit.sv
verilog/mips_regfile.sv
verilog/mips_alu.sv
verilog/mips_core.sv
testbench/mips_checker.sv
testbench/mips_tb.sv

/* testbench/mips_checker.sv */
// Wishbone classic master protocol assertions and their bind into mips_core
`default_nettype none

module mips_checker (
    input logic            clk,
    input logic            rst_n,
    input logic            wb_cyc,
    input logic            wb_stb,
    input logic            wb_we,
    input mips_pkg::word_t wb_adr,
    input mips_pkg::word_t wb_dat_w,
    input logic            wb_ack
);

    int unsigned violations = 0;  // Counts assertion failures for the testbench

    stb_in_cycle: assert property (@(posedge clk) disable iff (!rst_n) wb_stb |-> wb_cyc)
        else begin
            violations++;
            $error("wb_stb high without wb_cyc");
        end

    // Request held steady through wait states
    req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (wb_stb && !wb_ack) |=>
            ($stable(wb_adr) && $stable(wb_we) && $stable(wb_dat_w)))
        else begin
            violations++;
            $error("Request changed before wb_ack");
        end

    // Single transfers only
    stb_drop: assert property (@(posedge clk) disable iff (!rst_n)
        (wb_stb && wb_ack) |=> !wb_stb)
        else begin
            violations++;
            $error("wb_stb still high after wb_ack");
        end

    reset_idle: assert property (@(posedge clk) !rst_n |=> !wb_cyc)
        else begin
            violations++;
            $error("wb_cyc high during reset");
        end

endmodule

bind mips_core mips_checker u_checker (
    .clk      (clk),
    .rst_n    (rst_n),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_ack   (wb_ack)
);

`default_nettype wire

/* testbench/mips_tb.sv */
// Testbench with clock, reset, random program, Wishbone memory with wait states, ISA model, checks
`default_nettype none

module mips_tb;

    typedef enum {NEXT_FETCH, NEXT_LOAD, NEXT_STORE} next_access_t;

    logic            clk;
    logic            rst_n;
    logic            wb_cyc;
    logic            wb_stb;
    logic            wb_we;
    mips_pkg::word_t wb_adr;
    mips_pkg::word_t wb_dat_w;
    mips_pkg::word_t wb_dat_r;
    logic            wb_ack;

    integer          seed;
    int              wait_cnt;          // Wait states left before the next ack
    mips_pkg::word_t prog [200];        // Program words from RESET_PC
    mips_pkg::word_t data_mem [16];     // Data window at byte address 0
    mips_pkg::word_t data_model [16];   // Model view of the same window
    mips_pkg::word_t mregs [32];        // Model register file
    mips_pkg::word_t model_pc;
    mips_pkg::word_t last_fetch;
    mips_pkg::word_t exp_adr;           // Pending lw or sw access
    mips_pkg::word_t exp_dat;
    next_access_t    next_access;
    int              fetches;
    logic            done;              // Final self-jump seen

    mips_core dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic abort_run();
        $display("Something failed");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic compare_word(input string name, input mips_pkg::word_t exp,
                                input mips_pkg::word_t act);
        assert (act === exp) else begin
            $display("Mismatch %s: expected %h, actual %h", name, exp, act);
            abort_run();
        end
    endtask

    function automatic int rand_below(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic mips_pkg::word_t rtype_word(input mips_pkg::funct_t fn,
                                                   input int rs, rt, rd);
        return {mips_pkg::OP_RTYPE, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
    endfunction

    function automatic mips_pkg::word_t itype_word(input mips_pkg::opcode_t op,
                                                   input int rs, rt, input logic [15:0] imm);
        return {op, 5'(rs), 5'(rt), imm};
    endfunction

    // Mixes every address bit
    function automatic mips_pkg::word_t fill_value(input mips_pkg::word_t addr);
        return (addr * 32'h0101_0101) ^ 32'h3c6e_f372;
    endfunction

    function automatic mips_pkg::word_t mem_read(input mips_pkg::word_t adr);
        mips_pkg::word_t off;
        off = adr - mips_pkg::RESET_PC;
        if (adr < 64) return data_mem[adr[5:2]];
        if (off < 800) return prog[off[9:2]];
        return '0;
    endfunction

    task automatic build_program();
        mips_pkg::funct_t fns [5];
        int               kind;
        fns = '{mips_pkg::FN_ADD, mips_pkg::FN_SUB, mips_pkg::FN_AND,
                mips_pkg::FN_OR, mips_pkg::FN_SLT};
        for (int i = 0; i < 16; i++) begin
            data_mem[i]   = fill_value(32'(i * 4));
            data_model[i] = data_mem[i];
        end
        // Seed r1 to r7 first
        for (int i = 0; i < 7; i++) begin
            prog[i] = itype_word(mips_pkg::OP_ADDI, 0, i + 1, 16'(rand_below(65536)));
        end
        for (int i = 7; i < 199; i++) begin
            kind = rand_below(10);
            if (kind > 7 && i > 190) kind = 0;  // Branch target stays before the j
            case (kind)
                0, 1, 2, 3: prog[i] = rtype_word(fns[rand_below(5)], rand_below(8),
                                                 rand_below(8), 1 + rand_below(7));
                4, 5: prog[i] = itype_word(mips_pkg::OP_ADDI, rand_below(8), 1 + rand_below(7),
                                           16'(rand_below(65536)));
                6: prog[i] = itype_word(mips_pkg::OP_LW, 0, 1 + rand_below(7),
                                        16'(4 * rand_below(16)));
                7: prog[i] = itype_word(mips_pkg::OP_SW, 0, rand_below(8),
                                        16'(4 * rand_below(16)));  // rt of 0 stores zero
                default: prog[i] = itype_word(mips_pkg::OP_BEQ, rand_below(8), rand_below(8),
                                              16'(1 + rand_below(4)));
            endcase
        end
        prog[199] = {mips_pkg::OP_J, 26'((mips_pkg::RESET_PC + 32'd796) >> 2)};  // Self loop
    endtask

    // Runs one instruction of the ISA at its fetch
    task automatic step_model();
        mips_pkg::word_t ins;
        mips_pkg::word_t a;
        mips_pkg::word_t b;
        mips_pkg::word_t imm;
        ins      = mem_read(model_pc);
        a        = mregs[ins[25:21]];
        b        = mregs[ins[20:16]];
        imm      = {{16{ins[15]}}, ins[15:0]};
        model_pc = model_pc + 4;
        case (ins[31:26])
            mips_pkg::OP_RTYPE: begin
                case (ins[5:0])
                    mips_pkg::FN_SUB: mregs[ins[15:11]] = a - b;
                    mips_pkg::FN_AND: mregs[ins[15:11]] = a & b;
                    mips_pkg::FN_OR:  mregs[ins[15:11]] = a | b;
                    mips_pkg::FN_SLT: mregs[ins[15:11]] = {31'd0, $signed(a) < $signed(b)};
                    default:          mregs[ins[15:11]] = a + b;
                endcase
            end
            mips_pkg::OP_ADDI: mregs[ins[20:16]] = a + imm;
            mips_pkg::OP_LW: begin
                exp_adr            = a + imm;
                mregs[ins[20:16]]  = data_model[exp_adr[5:2]];
                next_access        = NEXT_LOAD;
            end
            mips_pkg::OP_SW: begin
                exp_adr                  = a + imm;
                exp_dat                  = b;
                data_model[exp_adr[5:2]] = b;
                next_access              = NEXT_STORE;
            end
            mips_pkg::OP_BEQ: if (a == b) model_pc = model_pc + (imm << 2);
            mips_pkg::OP_J:   model_pc = {model_pc[31:28], ins[25:0], 2'b00};
            default: ;
        endcase
        mregs[0] = '0;
    endtask

    // Memory slave with 0 to 3 wait states per access
    always @(posedge clk) begin
        wb_ack <= 1'b0;
        if (rst_n && wb_cyc && wb_stb && !wb_ack) begin
            if (wait_cnt == 0) begin
                wb_ack   <= 1'b1;
                wait_cnt <= rand_below(4);
                if (!wb_we) wb_dat_r <= mem_read(wb_adr);
                else if (wb_adr < 64) data_mem[wb_adr[5:2]] = wb_dat_w;
            end else begin
                wait_cnt <= wait_cnt - 1;
            end
        end
    end

    // Bus monitor comparing each completed transfer with the model
    always @(posedge clk) begin
        if (rst_n) begin
            assert (dut_i.u_checker.violations == 0) else begin
                $display("Wishbone protocol checker reported a violation");
                abort_run();
            end
        end
        if (rst_n && wb_cyc && wb_stb && wb_ack) begin
            case (next_access)
                NEXT_LOAD, NEXT_STORE: begin
                    assert (wb_we == (next_access == NEXT_STORE)) else begin
                        $display("Bus direction differs from the lw or sw being executed");
                        abort_run();
                    end
                    compare_word("data_addr", exp_adr, wb_adr);
                    if (next_access == NEXT_STORE) compare_word("sw_data", exp_dat, wb_dat_w);
                    next_access = NEXT_FETCH;
                end
                default: begin
                    assert (!wb_we) else begin
                        $display("Write cycle seen where an instruction fetch was expected");
                        abort_run();
                    end
                    if (fetches == 0) compare_word("first_fetch", mips_pkg::RESET_PC, wb_adr);
                    else compare_word("fetch_pc", model_pc, wb_adr);
                    if (fetches > 0 && wb_adr == last_fetch) done = 1'b1;
                    else step_model();
                    last_fetch = wb_adr;
                    fetches++;
                end
            endcase
        end
    end

    initial begin
        int cycles;
        int idle;
        seed        = 32'h0bd0_95ba;
        rst_n       <= 1'b0;
        wb_ack      <= 1'b0;
        wb_dat_r    <= '0;
        wait_cnt    <= 0;
        model_pc    = mips_pkg::RESET_PC;
        last_fetch  = '0;
        next_access = NEXT_FETCH;
        fetches     = 0;
        done        = 1'b0;
        cycles      = 0;
        idle        = 0;
        for (int i = 0; i < 32; i++) mregs[i] = '0;
        build_program();
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        assert (!wb_cyc && !wb_stb && !wb_we) else begin
            $display("Bus signals active in the first cycle after reset");
            abort_run();
        end
        while (!done && cycles < 20000) begin
            @(posedge clk);
            cycles++;
            idle = wb_ack ? 0 : idle + 1;
            assert (idle < 50) else begin
                $display("Timeout: no bus acknowledge for 50 cycles");
                abort_run();
            end
        end
        assert (done) begin
            $display("Everything OK");
            $finish;
        end else begin
            $display("Timeout: program never reached its final self-jump");
            abort_run();
        end
    end

endmodule

`default_nettype wire

/* verilog/mips_alu.sv */
// ALU block: sign extension, operand muxes, add/sub/and/or/slt, zero flag, ALUOut register
`default_nettype none

module mips_alu (
    input  logic              clk,
    input  logic              rst_n,
    mips_ctrl_if.exec         ctrl,
    input  mips_pkg::word_t   pc,
    input  mips_pkg::word_t   a_data,
    input  mips_pkg::word_t   b_data,
    output mips_pkg::word_t   alu_result,
    output mips_pkg::word_t   alu_out
);

    mips_pkg::word_t imm_ext;   // Sign-extended immediate
    mips_pkg::word_t imm_sh;    // Word offset in bytes
    mips_pkg::word_t src_a;
    mips_pkg::word_t src_b;

    assign imm_ext = {{16{ctrl.instr[15]}}, ctrl.instr[15:0]};
    assign imm_sh  = {imm_ext[29:0], 2'b00};

    assign src_a = ctrl.alu_src_a ? a_data : pc;

    always_comb begin
        case (ctrl.alu_src_b)
            mips_pkg::SRC_B_FOUR:   src_b = 32'd4;
            mips_pkg::SRC_B_IMM:    src_b = imm_ext;
            mips_pkg::SRC_B_IMM_SH: src_b = imm_sh;
            default:                src_b = b_data;
        endcase
    end

    always_comb begin
        case (ctrl.alu_op)
            mips_pkg::ALU_SUB: alu_result = src_a - src_b;
            mips_pkg::ALU_AND: alu_result = src_a & src_b;
            mips_pkg::ALU_OR:  alu_result = src_a | src_b;
            mips_pkg::ALU_SLT: alu_result = ($signed(src_a) < $signed(src_b)) ? 32'd1 : 32'd0;
            default:           alu_result = src_a + src_b;  // ALU_ADD
        endcase
    end

    assign ctrl.zero = (alu_result == '0);  // beq compares through A - B

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            alu_out <= '0;
        end else if (ctrl.alu_out_en) begin
            alu_out <= alu_result;
        end
    end

endmodule

`default_nettype wire

/* verilog/mips_control.sv */
// Multicycle control FSM with opcode and funct decode and Wishbone master handshake
`default_nettype none

module mips_control (
    input  logic      clk,
    input  logic      rst_n,
    mips_ctrl_if.ctrl ctrl,
    output logic      wb_cyc,
    output logic      wb_stb,
    output logic      wb_we,
    input  logic      wb_ack
);

    typedef enum logic [3:0] {
        FETCH,
        DECODE,
        MEM_ADDR,
        MEM_READ,
        MEM_WRITE,
        MEM_WB,
        EXECUTE,
        ALU_WB,
        BRANCH,
        JUMP
    } state_t;

    state_t              state;
    state_t              state_nxt;
    logic                bus_req;    // Registered CYC and STB
    logic                bus_we;
    logic                bus_done;   // Ack of the transfer in progress
    logic                bus_state;  // States that own a bus access
    mips_pkg::opcode_t   opcode;
    mips_pkg::funct_t    funct;
    logic                is_rtype;
    mips_pkg::alu_op_t   funct_op;   // ALU op from funct field

    assign opcode    = ctrl.instr[31:26];
    assign funct     = ctrl.instr[5:0];
    assign is_rtype  = (opcode == mips_pkg::OP_RTYPE);
    assign bus_done  = bus_req && wb_ack;  // Ignore a stray ack outside a request
    assign bus_state = (state == FETCH) || (state == MEM_READ) || (state == MEM_WRITE);

    always_comb begin
        case (funct)
            mips_pkg::FN_SUB: funct_op = mips_pkg::ALU_SUB;
            mips_pkg::FN_AND: funct_op = mips_pkg::ALU_AND;
            mips_pkg::FN_OR:  funct_op = mips_pkg::ALU_OR;
            mips_pkg::FN_SLT: funct_op = mips_pkg::ALU_SLT;
            default:          funct_op = mips_pkg::ALU_ADD;  // FN_ADD and unknowns
        endcase
    end

    // State and bus request; request rises one cycle after entering a bus state
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= FETCH;
            bus_req <= 1'b0;
            bus_we  <= 1'b0;
        end else begin
            state <= state_nxt;
            if (bus_done) begin
                bus_req <= 1'b0;  // Single transfer, drop after ack
                bus_we  <= 1'b0;
            end else if (!bus_req && bus_state) begin
                bus_req <= 1'b1;
                bus_we  <= (state == MEM_WRITE);
            end
        end
    end

    assign wb_cyc = bus_req;
    assign wb_stb = bus_req;
    assign wb_we  = bus_we;

    // Next state and datapath controls
    always_comb begin
        state_nxt       = state;
        ctrl.pc_write   = 1'b0;
        ctrl.ir_write   = 1'b0;
        ctrl.data_write = 1'b0;
        ctrl.iord       = 1'b0;
        ctrl.reg_write  = 1'b0;
        ctrl.reg_dst    = 1'b0;
        ctrl.mem_to_reg = 1'b0;
        ctrl.alu_src_a  = 1'b0;                   // PC
        ctrl.alu_src_b  = mips_pkg::SRC_B_REG;
        ctrl.alu_op     = mips_pkg::ALU_ADD;
        ctrl.alu_out_en = 1'b0;
        ctrl.pc_src     = mips_pkg::PC_SRC_ALU;
        case (state)
            FETCH: begin
                ctrl.alu_src_b = mips_pkg::SRC_B_FOUR;  // PC + 4 alongside the read
                ctrl.ir_write  = bus_done;
                ctrl.pc_write  = bus_done;
                if (bus_done) state_nxt = DECODE;
            end
            DECODE: begin
                // Branch target computed early, kept in ALUOut
                ctrl.alu_src_b  = mips_pkg::SRC_B_IMM_SH;
                ctrl.alu_out_en = 1'b1;
                case (opcode)
                    mips_pkg::OP_LW,
                    mips_pkg::OP_SW:    state_nxt = MEM_ADDR;
                    mips_pkg::OP_RTYPE,
                    mips_pkg::OP_ADDI:  state_nxt = EXECUTE;
                    mips_pkg::OP_BEQ:   state_nxt = BRANCH;
                    mips_pkg::OP_J:     state_nxt = JUMP;
                    default:            state_nxt = FETCH;  // Unsupported, acts as nop
                endcase
            end
            MEM_ADDR: begin
                ctrl.alu_src_a  = 1'b1;                  // Base + offset
                ctrl.alu_src_b  = mips_pkg::SRC_B_IMM;
                ctrl.alu_out_en = 1'b1;
                state_nxt = (opcode == mips_pkg::OP_LW) ? MEM_READ : MEM_WRITE;
            end
            MEM_READ: begin
                ctrl.iord       = 1'b1;
                ctrl.data_write = bus_done;
                if (bus_done) state_nxt = MEM_WB;
            end
            MEM_WRITE: begin
                ctrl.iord = 1'b1;
                if (bus_done) state_nxt = FETCH;
            end
            MEM_WB: begin
                ctrl.reg_write  = 1'b1;                  // rt <= loaded word
                ctrl.mem_to_reg = 1'b1;
                state_nxt = FETCH;
            end
            EXECUTE: begin
                ctrl.alu_src_a  = 1'b1;
                ctrl.alu_src_b  = is_rtype ? mips_pkg::SRC_B_REG : mips_pkg::SRC_B_IMM;
                ctrl.alu_op     = is_rtype ? funct_op : mips_pkg::ALU_ADD;  // addi adds
                ctrl.alu_out_en = 1'b1;
                state_nxt = ALU_WB;
            end
            ALU_WB: begin
                ctrl.reg_write = 1'b1;
                ctrl.reg_dst   = is_rtype;               // rd for R-type, rt for addi
                state_nxt = FETCH;
            end
            BRANCH: begin
                ctrl.alu_src_a = 1'b1;                   // A - B sets zero
                ctrl.alu_op    = mips_pkg::ALU_SUB;
                ctrl.pc_src    = mips_pkg::PC_SRC_ALUOUT;
                ctrl.pc_write  = ctrl.zero;
                state_nxt = FETCH;
            end
            JUMP: begin
                ctrl.pc_src   = mips_pkg::PC_SRC_JUMP;
                ctrl.pc_write = 1'b1;
                state_nxt = FETCH;
            end
            default: state_nxt = FETCH;
        endcase
    end

endmodule

`default_nettype wire

/* verilog/mips_core.sv */
// Multicycle MIPS core top: control FSM, fetch unit, register file and ALU on a Wishbone bus
`default_nettype none

module mips_core (
    input  logic              clk,
    input  logic              rst_n,
    output logic              wb_cyc,
    output logic              wb_stb,
    output logic              wb_we,
    output mips_pkg::word_t   wb_adr,
    output mips_pkg::word_t   wb_dat_w,
    input  mips_pkg::word_t   wb_dat_r,
    input  logic              wb_ack
);

    mips_pkg::word_t pc;
    mips_pkg::word_t alu_result;  // Combinational, feeds PC + 4
    mips_pkg::word_t alu_out;
    mips_pkg::word_t a_data;
    mips_pkg::word_t b_data;
    mips_pkg::word_t mem_data;    // Loaded word for lw write-back

    mips_ctrl_if ctrl_bus ();

    mips_control u_control (
        .clk    (clk),
        .rst_n  (rst_n),
        .ctrl   (ctrl_bus.ctrl),
        .wb_cyc (wb_cyc),
        .wb_stb (wb_stb),
        .wb_we  (wb_we),
        .wb_ack (wb_ack)
    );

    mips_fetch_unit u_fetch (
        .clk        (clk),
        .rst_n      (rst_n),
        .ctrl       (ctrl_bus.fetch),
        .alu_result (alu_result),
        .alu_out    (alu_out),
        .b_data     (b_data),
        .wb_adr     (wb_adr),
        .wb_dat_w   (wb_dat_w),
        .wb_dat_r   (wb_dat_r),
        .pc         (pc),
        .mem_data   (mem_data)
    );

    mips_regfile u_regfile (
        .clk      (clk),
        .rst_n    (rst_n),
        .ctrl     (ctrl_bus.exec),
        .alu_out  (alu_out),
        .mem_data (mem_data),
        .a_data   (a_data),
        .b_data   (b_data)
    );

    mips_alu u_alu (
        .clk        (clk),
        .rst_n      (rst_n),
        .ctrl       (ctrl_bus.exec),
        .pc         (pc),
        .a_data     (a_data),
        .b_data     (b_data),
        .alu_result (alu_result),
        .alu_out    (alu_out)
    );

endmodule

`default_nettype wire

/* verilog/mips_ctrl_if.sv */
// Control interface: enables, mux selects and status flags between FSM and datapath
`default_nettype none

interface mips_ctrl_if;

    logic                pc_write;    // PC load
    logic                ir_write;    // Instruction register load
    logic                data_write;  // Memory data register load
    logic                iord;        // Bus address, 0 PC, 1 ALUOut
    logic                reg_write;   // Register file write enable
    logic                reg_dst;     // Destination, 0 rt, 1 rd
    logic                mem_to_reg;  // Write-back, 0 ALUOut, 1 memory data
    logic                alu_src_a;   // First operand, 0 PC, 1 register A
    mips_pkg::src_b_t    alu_src_b;
    mips_pkg::alu_op_t   alu_op;
    logic                alu_out_en;  // ALUOut load
    mips_pkg::pc_src_t   pc_src;

    // Status back to the FSM
    logic                zero;
    mips_pkg::word_t     instr;       // Instruction register contents

    modport ctrl (
        output pc_write, ir_write, data_write, iord, reg_write, reg_dst,
               mem_to_reg, alu_src_a, alu_src_b, alu_op, alu_out_en, pc_src,
        input  zero, instr
    );

    modport fetch (
        input  pc_write, ir_write, data_write, iord, pc_src,
        output instr
    );

    // Shared by register file and ALU
    modport exec (
        input  instr, reg_write, reg_dst, mem_to_reg, alu_src_a, alu_src_b,
               alu_op, alu_out_en,
        output zero
    );

endinterface

`default_nettype wire

/* verilog/mips_fetch_unit.sv */
// Fetch unit: PC, next-PC mux, instruction and memory data registers, bus address and data
`default_nettype none

module mips_fetch_unit (
    input  logic              clk,
    input  logic              rst_n,
    mips_ctrl_if.fetch        ctrl,
    input  mips_pkg::word_t   alu_result,
    input  mips_pkg::word_t   alu_out,
    input  mips_pkg::word_t   b_data,
    output mips_pkg::word_t   wb_adr,
    output mips_pkg::word_t   wb_dat_w,
    input  mips_pkg::word_t   wb_dat_r,
    output mips_pkg::word_t   pc,
    output mips_pkg::word_t   mem_data
);

    mips_pkg::word_t pc_nxt;
    mips_pkg::word_t jump_target;
    mips_pkg::word_t ir;           // Instruction register

    // PC already holds PC + 4 when j executes
    assign jump_target = {pc[31:28], ir[25:0], 2'b00};

    always_comb begin
        case (ctrl.pc_src)
            mips_pkg::PC_SRC_ALUOUT: pc_nxt = alu_out;      // Taken beq
            mips_pkg::PC_SRC_JUMP:   pc_nxt = jump_target;
            default:                 pc_nxt = alu_result;   // Sequential PC + 4
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= mips_pkg::RESET_PC;
        end else if (ctrl.pc_write) begin
            pc <= pc_nxt;
        end
    end

    // Both capture the read data in the ack cycle
    always_ff @(posedge clk) begin
        if (ctrl.ir_write) ir <= wb_dat_r;
        if (ctrl.data_write) mem_data <= wb_dat_r;
    end

    assign ctrl.instr = ir;

    // Instruction fetch from PC, data access from ALUOut
    assign wb_adr   = ctrl.iord ? alu_out : pc;
    assign wb_dat_w = b_data;  // Store data is rt, held in B

endmodule

`default_nettype wire

/* verilog/mips_pkg.sv */
// Core word and field types, opcode and funct codes, ALU and mux select codes, reset PC
`default_nettype none

package mips_pkg;

    typedef logic [31:0] word_t;      // Data word, byte address or instruction
    typedef logic [4:0]  reg_addr_t;  // Register number
    typedef logic [2:0]  alu_op_t;    // ALU operation
    typedef logic [5:0]  opcode_t;    // Instruction bits 31:26
    typedef logic [5:0]  funct_t;     // R-type bits 5:0
    typedef logic [1:0]  src_b_t;     // Second ALU operand select
    typedef logic [1:0]  pc_src_t;    // Next PC select

    // Boot address of the program
    localparam word_t RESET_PC = 32'h0040_0000;

    // ALU operations, classic MIPS control encoding
    localparam alu_op_t ALU_AND = 3'b000;
    localparam alu_op_t ALU_OR  = 3'b001;
    localparam alu_op_t ALU_ADD = 3'b010;
    localparam alu_op_t ALU_SUB = 3'b110;
    localparam alu_op_t ALU_SLT = 3'b111;

    // Opcodes of the supported subset
    localparam opcode_t OP_RTYPE = 6'h00;
    localparam opcode_t OP_J     = 6'h02;
    localparam opcode_t OP_BEQ   = 6'h04;
    localparam opcode_t OP_ADDI  = 6'h08;
    localparam opcode_t OP_LW    = 6'h23;
    localparam opcode_t OP_SW    = 6'h2b;

    // R-type funct codes
    localparam funct_t FN_ADD = 6'h20;
    localparam funct_t FN_SUB = 6'h22;
    localparam funct_t FN_AND = 6'h24;
    localparam funct_t FN_OR  = 6'h25;
    localparam funct_t FN_SLT = 6'h2a;

    // Second ALU operand
    localparam src_b_t SRC_B_REG    = 2'd0;  // Register B
    localparam src_b_t SRC_B_FOUR   = 2'd1;  // Constant 4 for PC + 4
    localparam src_b_t SRC_B_IMM    = 2'd2;  // Sign-extended immediate
    localparam src_b_t SRC_B_IMM_SH = 2'd3;  // Immediate times 4, branch offset

    // Next PC source
    localparam pc_src_t PC_SRC_ALU    = 2'd0;  // Combinational ALU result
    localparam pc_src_t PC_SRC_ALUOUT = 2'd1;  // Branch target held in ALUOut
    localparam pc_src_t PC_SRC_JUMP   = 2'd2;  // Pseudo-direct jump target

endpackage

`default_nettype wire

/* verilog/mips_regfile.sv */
// Register file: 32 x 32 array, destination and write-back muxes, A and B read registers
`default_nettype none

module mips_regfile (
    input  logic              clk,
    input  logic              rst_n,
    mips_ctrl_if.exec         ctrl,
    input  mips_pkg::word_t   alu_out,
    input  mips_pkg::word_t   mem_data,
    output mips_pkg::word_t   a_data,
    output mips_pkg::word_t   b_data
);

    mips_pkg::word_t     regs [32];
    mips_pkg::reg_addr_t rs;
    mips_pkg::reg_addr_t rt;
    mips_pkg::reg_addr_t rd;
    mips_pkg::reg_addr_t dst;
    mips_pkg::word_t     wr_data;
    mips_pkg::word_t     rd_a;      // Combinational read ports
    mips_pkg::word_t     rd_b;

    assign rs = ctrl.instr[25:21];
    assign rt = ctrl.instr[20:16];
    assign rd = ctrl.instr[15:11];

    assign dst     = ctrl.reg_dst ? rd : rt;
    assign wr_data = ctrl.mem_to_reg ? mem_data : alu_out;

    // $zero always reads zero
    assign rd_a = (rs == '0) ? '0 : regs[rs];
    assign rd_b = (rt == '0) ? '0 : regs[rt];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (ctrl.reg_write && (dst != '0)) begin
            regs[dst] <= wr_data;
        end
    end

    // Reloaded each cycle; IR and the array stay unchanged until write-back,
    // so the values taken at the end of decode hold for the whole instruction
    always_ff @(posedge clk) begin
        a_data <= rd_a;
        b_data <= rd_b;
    end

endmodule

`default_nettype wire
